// File: project.f
source/spiRegPkg.sv
source/spiTarget.sv
source/cursorScanner.sv
source/busArbiter.sv
source/registerBank.sv
source/spiRegisterTop.sv
verification/spiRegisterTop_checker.sv
verification/spiRegisterTb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the register block testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
simName=spiRegisterSim
logFile=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module spiRegisterTb \
	-f project.f \
	-Mdir "$buildDir" \
	-o "$simName"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$buildDir/$simName" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "tests failed" "$logFile"; then
	echo "Simulation reported failures, see $logFile"
	exit 1
fi

echo "Simulation finished without failures"
exit 0

// File: verification/spiRegisterTb.sv
// SPI register block testbench
`timescale 1ns/1ps

module spiRegisterTb import spiRegPkg::*; ();

	localparam int HalfPeriod = 8; // System clocks per SPI half period
	localparam int StrobeGap = 20;
	localparam int StrobeCount = 53;
	localparam int RowLength = 4; // Mode nibble 3 gives four columns
	localparam int IrqWaitLimit = 40;
	localparam int KindRead = 0;
	localparam int KindWrite = 1;
	localparam int KindStrobe = 2;
	localparam int KindAbort = 3;
	localparam int KindIdle = 4;

	logic theClock = 1'b0;
	logic SPI_counter_reset;
	logic spiClk;
	logic spiCs;
	logic spiSdi;
	logic spiSdo;
	logic irq;
	logic pixelStrobe;
	logic [DataWidth-1:0] configOut;
	logic [DataWidth-1:0] ledOut;
	logic [DataWidth-1:0] pixelR;
	logic [DataWidth-1:0] pixelG;
	logic [DataWidth-1:0] pixelB;

	// Stimulus table, one column per queue
	int kindQ[$];
	logic [AddrWidth-1:0] addrQ[$];
	logic [DataWidth-1:0] dataQ[$];
	logic [DataWidth-1:0] expQ[$];
	string labelQ[$];

	integer seed;
	int cycleCount = 0;
	int cycleLimit = 2000;
	int irqCount = 0;
	int errorCount = 0;
	int passCount = 0;
	int failCount = 0;

	spiRegisterTop i_spiRegisterTop (
		.theClock(theClock),
		.SPI_counter_reset(SPI_counter_reset),
		.spiClk(spiClk),
		.spiCs(spiCs),
		.spiSdi(spiSdi),
		.spiSdo(spiSdo),
		.irq(irq),
		.pixelStrobe(pixelStrobe),
		.configOut(configOut),
		.ledOut(ledOut),
		.pixelR(pixelR),
		.pixelG(pixelG),
		.pixelB(pixelB)
	);

	always
	begin
		#5 theClock = ~theClock;
	end

	always @(posedge theClock)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("Timeout: run did not finish within %0d cycles", cycleLimit);
			$display("tests failed");
			$finish;
		end
	end

	always @(negedge theClock)
	begin
		if (!SPI_counter_reset && irq)
			irqCount <= irqCount + 1; // Counted where irq is stable
	end

	task automatic compareValue(input string name, input logic [7:0] actual,
		input logic [7:0] expected);
		if (actual !== expected)
		begin
			$display("ERROR at %0t: %s is 0x%02h, expected 0x%02h", $time, name, actual,
				expected);
			errorCount++;
		end
	endtask

	task automatic addEntry(input int kind, input logic [6:0] addr, input logic [7:0] data,
		input logic [7:0] expValue, input string label);
		kindQ.push_back(kind);
		addrQ.push_back(addr);
		dataQ.push_back(data);
		expQ.push_back(expValue);
		labelQ.push_back(label);
	endtask

	task automatic buildTable();
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
		logic [7:0] expX;
		logic [7:0] expY;
		red = 8'($random(seed));
		green = 8'($random(seed));
		blue = 8'($random(seed));
		expX = 8'(StrobeCount % RowLength);
		expY = 8'((StrobeCount / RowLength) % ScanRows); // Y wraps after the last row
		addEntry(KindIdle, 7'h00, 8'h00, 8'h00, "outputs after reset");
		addEntry(KindWrite, AddrConfig, 8'hA4, 8'hA4, "write Config");
		addEntry(KindRead, AddrConfig, 8'h00, 8'hA4, "read Config");
		addEntry(KindWrite, AddrLed, 8'h5A, 8'h5A, "write Led");
		addEntry(KindRead, AddrLed, 8'h00, 8'h5A, "read Led");
		addEntry(KindWrite, AddrPixelR, red, red, "write PixelR");
		addEntry(KindRead, AddrPixelR, 8'h00, red, "read PixelR");
		addEntry(KindWrite, AddrPixelG, green, green, "write PixelG");
		addEntry(KindRead, AddrPixelG, 8'h00, green, "read PixelG");
		addEntry(KindWrite, AddrPixelB, blue, blue, "write PixelB");
		addEntry(KindRead, AddrPixelB, 8'h00, blue, "read PixelB");
		addEntry(KindWrite, AddrMode, 8'hA3, 8'hA3, "write Mode");
		addEntry(KindRead, AddrMode, 8'h00, 8'hA3, "read Mode");
		addEntry(KindRead, 7'h40, 8'h00, UnmappedValue, "read unmapped 0x40");
		addEntry(KindRead, 7'h7F, 8'h00, UnmappedValue, "read unmapped 0x7F");
		addEntry(KindWrite, AddrConfig, 8'h01, 8'h01, "enable scanner");
		addEntry(KindStrobe, 7'h00, 8'(StrobeCount), 8'h00, "strobes while enabled");
		addEntry(KindRead, AddrPosX, 8'h00, expX, "read PosX");
		addEntry(KindRead, AddrPosY, 8'h00, expY, "read PosY");
		addEntry(KindRead, AddrCounter, 8'h00, 8'(StrobeCount), "read Counter");
		addEntry(KindWrite, AddrConfig, 8'h00, 8'h00, "disable scanner");
		addEntry(KindStrobe, 7'h00, 8'd5, 8'h00, "strobes while disabled");
		addEntry(KindRead, AddrCounter, 8'h00, 8'(StrobeCount), "Counter unchanged");
		addEntry(KindRead, AddrPosX, 8'h00, expX, "PosX unchanged");
		addEntry(KindWrite, AddrPosX, 8'h55, 8'h00, "SPI write to PosX");
		addEntry(KindRead, AddrPosX, 8'h00, expX, "PosX keeps scanner value");
		addEntry(KindRead, AddrLastWrite, 8'h00, 8'(AddrPosX), "LastWrite after PosX write");
		addEntry(KindAbort, AddrLed, 8'hFF, 8'h5A, "aborted Led write");
		addEntry(KindRead, AddrLed, 8'h00, 8'h5A, "Led after abort");
		addEntry(KindRead, AddrLastWrite, 8'h00, 8'(AddrPosX), "LastWrite after abort");
	endtask

	// Mode 0 bit bang, MSB first, sdo sampled just before each rising edge
	task automatic shiftByte(input logic [7:0] txByte, input int bits, output logic [7:0] rxByte);
		int i;
		rxByte = 8'h00;
		for (i = 7; i > 7 - bits; i--)
		begin
			spiSdi = txByte[i];
			repeat (HalfPeriod) @(negedge theClock);
			rxByte = {rxByte[6:0], spiSdo};
			spiClk = 1'b1;
			repeat (HalfPeriod) @(negedge theClock);
			spiClk = 1'b0;
		end
	endtask

	task automatic spiTransfer(input logic isWrite, input logic [6:0] addr, input logic [7:0] data,
		output logic [7:0] readByte);
		logic [7:0] addrEcho;
		int waitCycles;
		spiCs = 1'b0;
		shiftByte({isWrite, addr}, 8, addrEcho);
		shiftByte(data, 8, readByte);
		waitCycles = 0;
		while (!irq && waitCycles < IrqWaitLimit)
		begin
			@(negedge theClock);
			waitCycles++;
		end
		if (!irq)
		begin
			$display("No irq pulse within %0d cycles of the data byte at %0t", IrqWaitLimit,
				$time);
			errorCount++;
		end
		@(negedge theClock); // Write has landed one cycle after irq
		spiCs = 1'b1;
	endtask

	task automatic spiAbort(input logic [6:0] addr, input int bits);
		logic [7:0] addrEcho;
		spiCs = 1'b0;
		shiftByte({1'b1, addr}, bits, addrEcho);
		spiCs = 1'b1;
		repeat (2 * HalfPeriod) @(negedge theClock);
	endtask

	task automatic pulseStrobes(input int count);
		repeat (count)
		begin
			pixelStrobe = 1'b1;
			@(negedge theClock);
			pixelStrobe = 1'b0;
			repeat (StrobeGap - 1) @(negedge theClock);
		end
	endtask

	task automatic checkTopOutput(input logic [6:0] addr, input logic [7:0] expected);
		case (addr)
			AddrConfig: compareValue("configOut", configOut, expected);
			AddrLed: compareValue("ledOut", ledOut, expected);
			AddrPixelR: compareValue("pixelR", pixelR, expected);
			AddrPixelG: compareValue("pixelG", pixelG, expected);
			AddrPixelB: compareValue("pixelB", pixelB, expected);
			default: ; // Register without a top-level output
		endcase
	endtask

	initial
	begin
		logic [7:0] readByte;
		int irqBefore;
		int errorsBefore;
		int expectedPulses;
		int n;
		SPI_counter_reset = 1'b1;
		spiClk = 1'b0;
		spiCs = 1'b1;
		spiSdi = 1'b0;
		pixelStrobe = 1'b0;
		seed = 15763;
		buildTable();
		cycleLimit = kindQ.size() * 300 + 2000;
		repeat (3) @(negedge theClock);
		SPI_counter_reset = 1'b0;
		for (n = 0; n < kindQ.size(); n++)
		begin
			errorsBefore = errorCount;
			irqBefore = irqCount;
			expectedPulses = 0;
			case (kindQ[n])
				KindRead:
				begin
					spiTransfer(1'b0, addrQ[n], 8'h00, readByte);
					compareValue("spiSdo byte", readByte, expQ[n]);
					expectedPulses = 1;
				end
				KindWrite:
				begin
					spiTransfer(1'b1, addrQ[n], dataQ[n], readByte);
					checkTopOutput(addrQ[n], expQ[n]);
					expectedPulses = 1;
				end
				KindStrobe:
					pulseStrobes(int'(dataQ[n]));
				KindAbort:
				begin
					spiAbort(addrQ[n], 4); // Deselect halfway through the address
					checkTopOutput(addrQ[n], expQ[n]);
				end
				default:
				begin
					repeat (20) @(negedge theClock);
					checkTopOutput(AddrConfig, 8'h00);
					checkTopOutput(AddrLed, 8'h00);
					checkTopOutput(AddrPixelR, 8'h00);
					checkTopOutput(AddrPixelG, 8'h00);
					checkTopOutput(AddrPixelB, 8'h00);
					compareValue("spiSdo", {7'b0, spiSdo}, 8'h00);
				end
			endcase
			compareValue("irq pulses", 8'(irqCount - irqBefore), 8'(expectedPulses));
			if (errorCount == errorsBefore)
			begin
				passCount++;
				$display("test %0d %s: ok", n, labelQ[n]);
			end
			else
			begin
				failCount++;
				$display("test %0d %s: FAIL", n, labelQ[n]);
			end
			repeat (HalfPeriod) @(negedge theClock);
		end
		$display("tests: %0d, passed: %0d, failed: %0d", kindQ.size(), passCount, failCount);
		if (failCount == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// File: verification/spiRegisterTop_checker.sv
// Bus and irq assertions
`timescale 1ns/1ps

module spiRegisterTop_checker (
	input logic theClock,
	input logic SPI_counter_reset,
	input logic irq,
	input logic spiRequest,
	input logic spiGrant,
	input logic scanRequest,
	input logic scanGrant
);

	irqSingle: assert property (@(posedge theClock) disable iff (SPI_counter_reset)
		irq |=> !irq)
		else $error("irq stayed high for two cycles");

	// One peer owns the bank per cycle
	grantsExclusive: assert property (@(posedge theClock) disable iff (SPI_counter_reset)
		!(spiGrant && scanGrant))
		else $error("spiGrant and scanGrant high together");

	spiGrantNeedsRequest: assert property (@(posedge theClock) disable iff (SPI_counter_reset)
		spiGrant |-> spiRequest)
		else $error("spiGrant without spiRequest");

	scanGrantNeedsRequest: assert property (@(posedge theClock) disable iff (SPI_counter_reset)
		scanGrant |-> scanRequest)
		else $error("scanGrant without scanRequest");

	resetQuiet: assert property (@(posedge theClock)
		SPI_counter_reset |=> (!irq && !spiGrant && !scanGrant))
		else $error("irq or a grant active right after reset");

endmodule

bind spiRegisterTop spiRegisterTop_checker i_checker (
	.theClock(theClock),
	.SPI_counter_reset(SPI_counter_reset),
	.irq(irq),
	.spiRequest(spiRequest),
	.spiGrant(spiGrant),
	.scanRequest(scanRequest),
	.scanGrant(scanGrant)
);

// File: source/spiRegisterTop.sv
// SPI register block top
`timescale 1ns/1ps

module spiRegisterTop import spiRegPkg::*; (
	input  logic theClock,
	input  logic SPI_counter_reset,
	input  logic spiClk,
	input  logic spiCs,
	input  logic spiSdi,
	output logic spiSdo,
	output logic irq,
	input  logic pixelStrobe,
	output logic [DataWidth-1:0] configOut,
	output logic [DataWidth-1:0] ledOut,
	output logic [DataWidth-1:0] pixelR,
	output logic [DataWidth-1:0] pixelG,
	output logic [DataWidth-1:0] pixelB
);

	logic spiRequest;
	logic spiGrant;
	busOp_t spiOp;
	logic [AddrWidth-1:0] spiAddr;
	logic [DataWidth-1:0] spiWriteData;

	logic scanRequest;
	logic scanGrant;
	busOp_t scanOp;
	logic [AddrWidth-1:0] scanAddr;
	logic [DataWidth-1:0] scanWriteData;

	logic bankWrite;
	logic [AddrWidth:0] bankAddr;
	logic [DataWidth-1:0] bankWriteData;
	logic [DataWidth-1:0] readData;
	logic [DataWidth-1:0] modeOut;

	spiTarget i_spiTarget (
		.theClock(theClock),
		.SPI_counter_reset(SPI_counter_reset),
		.spiClk(spiClk),
		.spiCs(spiCs),
		.spiSdi(spiSdi),
		.spiSdo(spiSdo),
		.irq(irq),
		.spiRequest(spiRequest),
		.spiOp(spiOp),
		.spiAddr(spiAddr),
		.spiWriteData(spiWriteData),
		.spiGrant(spiGrant),
		.readData(readData)
	);

	cursorScanner i_cursorScanner (
		.theClock(theClock),
		.SPI_counter_reset(SPI_counter_reset),
		.pixelStrobe(pixelStrobe),
		.scanEnable(configOut[0]), // Config bit 0
		.rowLast(modeOut[3:0]), // Mode low nibble
		.scanRequest(scanRequest),
		.scanOp(scanOp),
		.scanAddr(scanAddr),
		.scanWriteData(scanWriteData),
		.scanGrant(scanGrant)
	);

	busArbiter i_busArbiter (
		.theClock(theClock),
		.SPI_counter_reset(SPI_counter_reset),
		.spiRequest(spiRequest),
		.spiOp(spiOp),
		.spiAddr(spiAddr),
		.spiWriteData(spiWriteData),
		.scanRequest(scanRequest),
		.scanOp(scanOp),
		.scanAddr(scanAddr),
		.scanWriteData(scanWriteData),
		.spiGrant(spiGrant),
		.scanGrant(scanGrant),
		.bankWrite(bankWrite),
		.bankAddr(bankAddr),
		.bankWriteData(bankWriteData)
	);

	registerBank i_registerBank (
		.theClock(theClock),
		.SPI_counter_reset(SPI_counter_reset),
		.bankWrite(bankWrite),
		.bankAddr(bankAddr),
		.bankWriteData(bankWriteData),
		.readData(readData),
		.configOut(configOut),
		.ledOut(ledOut),
		.pixelR(pixelR),
		.pixelG(pixelG),
		.pixelB(pixelB),
		.modeOut(modeOut)
	);

endmodule

// File: source/registerBank.sv
// Shared register bank
`timescale 1ns/1ps

module registerBank import spiRegPkg::*; (
	input  logic theClock,
	input  logic SPI_counter_reset,
	input  logic bankWrite,
	input  logic [AddrWidth:0] bankAddr,
	input  logic [DataWidth-1:0] bankWriteData,
	output logic [DataWidth-1:0] readData,
	output logic [DataWidth-1:0] configOut,
	output logic [DataWidth-1:0] ledOut,
	output logic [DataWidth-1:0] pixelR,
	output logic [DataWidth-1:0] pixelG,
	output logic [DataWidth-1:0] pixelB,
	output logic [DataWidth-1:0] modeOut
);

	logic [AddrWidth-1:0] regAddr;
	logic scanAccess;
	logic [DataWidth-1:0] posX;
	logic [DataWidth-1:0] posY;
	logic [DataWidth-1:0] stepCount;
	logic [DataWidth-1:0] lastWrite;

	assign regAddr = bankAddr[AddrWidth-1:0];
	assign scanAccess = bankAddr[AddrWidth]; // Only the scanner fills read-only registers

	always_ff @(posedge theClock)
	begin
		if (SPI_counter_reset)
		begin
			configOut <= '0;
			ledOut <= '0;
			pixelR <= '0;
			pixelG <= '0;
			pixelB <= '0;
			modeOut <= '0;
			posX <= '0;
			posY <= '0;
			stepCount <= '0;
			lastWrite <= '0;
		end
		else if (bankWrite)
		begin
			lastWrite <= DataWidth'(regAddr); // Any peer, any address
			case (regAddr)
				AddrConfig: configOut <= bankWriteData;
				AddrMode: modeOut <= bankWriteData;
				AddrLed: ledOut <= bankWriteData;
				AddrPixelR: pixelR <= bankWriteData;
				AddrPixelG: pixelG <= bankWriteData;
				AddrPixelB: pixelB <= bankWriteData;
				AddrPosX: if (scanAccess) posX <= bankWriteData;
				AddrPosY: if (scanAccess) posY <= bankWriteData;
				AddrCounter: if (scanAccess) stepCount <= bankWriteData;
				default: ; // Unmapped writes only touch LastWrite
			endcase
		end
	end

	always_comb
	begin
		case (regAddr)
			AddrConfig: readData = configOut;
			AddrLastWrite: readData = lastWrite;
			AddrCounter: readData = stepCount;
			AddrPosX: readData = posX;
			AddrPosY: readData = posY;
			AddrMode: readData = modeOut;
			AddrPixelR: readData = pixelR;
			AddrPixelG: readData = pixelG;
			AddrPixelB: readData = pixelB;
			AddrLed: readData = ledOut;
			default: readData = UnmappedValue;
		endcase
	end

endmodule

// File: source/busArbiter.sv
// Fixed-priority bus arbiter
`timescale 1ns/1ps

module busArbiter import spiRegPkg::*; (
	input  logic theClock,
	input  logic SPI_counter_reset,
	input  logic spiRequest,
	input  busOp_t spiOp,
	input  logic [AddrWidth-1:0] spiAddr,
	input  logic [DataWidth-1:0] spiWriteData,
	input  logic scanRequest,
	input  busOp_t scanOp,
	input  logic [AddrWidth-1:0] scanAddr,
	input  logic [DataWidth-1:0] scanWriteData,
	output logic spiGrant,
	output logic scanGrant,
	output logic bankWrite,
	output logic [AddrWidth:0] bankAddr, // Top bit marks a scanner access
	output logic [DataWidth-1:0] bankWriteData
);

	logic spiBusy; // SPI access served last cycle

	always_ff @(posedge theClock)
	begin
		if (SPI_counter_reset)
			spiBusy <= 1'b0;
		else
			spiBusy <= spiGrant;
	end

	// The scanner moves to a new address on every grant, so only SPI can repeat
	assign spiGrant = spiRequest && !spiBusy;
	assign scanGrant = scanRequest && !spiGrant; // SPI first

	always_comb
	begin
		if (spiGrant)
		begin
			bankWrite = (spiOp == BusWrite);
			bankAddr = {1'b0, spiAddr};
			bankWriteData = spiWriteData;
		end
		else
		begin
			bankWrite = scanGrant && (scanOp == BusWrite);
			bankAddr = {1'b1, scanAddr};
			bankWriteData = scanWriteData;
		end
	end

endmodule

// File: source/cursorScanner.sv
// Cursor position scanner
`timescale 1ns/1ps

module cursorScanner import spiRegPkg::*; (
	input  logic theClock,
	input  logic SPI_counter_reset,
	input  logic pixelStrobe,
	input  logic scanEnable,
	input  logic [3:0] rowLast,
	output logic scanRequest,
	output busOp_t scanOp,
	output logic [AddrWidth-1:0] scanAddr,
	output logic [DataWidth-1:0] scanWriteData,
	input  logic scanGrant
);

	scanState_t scanState;
	logic [DataWidth-1:0] posX;
	logic [DataWidth-1:0] posY;
	logic [DataWidth-1:0] stepCount;
	logic strobeTaken;

	assign strobeTaken = pixelStrobe && scanEnable && (scanState == Idle); // Busy drops strobes

	always_ff @(posedge theClock)
	begin
		if (SPI_counter_reset)
		begin
			scanState <= Idle;
			posX <= '0;
			posY <= '0;
			stepCount <= '0;
		end
		else
		begin
			case (scanState)
				Idle:
					if (strobeTaken)
					begin
						stepCount <= stepCount + 1'b1;
						if (posX == DataWidth'(rowLast))
						begin
							posX <= '0; // End of row
							if (posY == DataWidth'(ScanRows - 1))
								posY <= '0;
							else
								posY <= posY + 1'b1;
						end
						else
							posX <= posX + 1'b1;
						scanState <= WriteX;
					end
				WriteX:
					if (scanGrant)
						scanState <= WriteY;
				WriteY:
					if (scanGrant)
						scanState <= WriteCount;
				WriteCount:
					if (scanGrant)
						scanState <= Idle;
				default:
					scanState <= Idle;
			endcase
		end
	end

	assign scanRequest = (scanState != Idle); // Held until granted
	assign scanOp = BusWrite;

	always_comb
	begin
		case (scanState)
			WriteY:
			begin
				scanAddr = AddrPosY;
				scanWriteData = posY;
			end
			WriteCount:
			begin
				scanAddr = AddrCounter;
				scanWriteData = stepCount;
			end
			default:
			begin
				scanAddr = AddrPosX;
				scanWriteData = posX;
			end
		endcase
	end

endmodule

// File: source/spiTarget.sv
// SPI register target
`timescale 1ns/1ps

module spiTarget import spiRegPkg::*; (
	input  logic theClock,
	input  logic SPI_counter_reset,
	input  logic spiClk,
	input  logic spiCs,
	input  logic spiSdi,
	output logic spiSdo,
	output logic irq,
	output logic spiRequest,
	output busOp_t spiOp,
	output logic [AddrWidth-1:0] spiAddr,
	output logic [DataWidth-1:0] spiWriteData,
	input  logic spiGrant,
	input  logic [DataWidth-1:0] readData
);

	spiState_t spiState;
	spiState_t spiNextState;

	logic [1:0] clkPipe;
	logic [1:0] csPipe;
	logic [1:0] sdiPipe;
	logic clkSync;
	logic csSync;
	logic sdiSync;

	logic [2:0] bitCount;
	logic bitCountClear;
	logic bitCountInc;

	logic [DataWidth-1:0] addrShift; // Write flag and address
	logic [DataWidth-1:0] dataShift; // Data in and out
	logic addrSample;
	logic dataSample;
	logic dataLoad;
	logic isWrite;

	assign clkSync = clkPipe[1];
	assign csSync = csPipe[1];
	assign sdiSync = sdiPipe[1];

	// Two flip-flops per SPI pin
	always_ff @(posedge theClock)
	begin
		if (SPI_counter_reset)
		begin
			clkPipe <= 2'b00;
			csPipe <= 2'b11; // Deselected
			sdiPipe <= 2'b00;
		end
		else
		begin
			clkPipe <= {clkPipe[0], spiClk};
			csPipe <= {csPipe[0], spiCs};
			sdiPipe <= {sdiPipe[0], spiSdi};
		end
	end

	always_ff @(posedge theClock)
	begin
		if (SPI_counter_reset)
			spiState <= Wait;
		else
			spiState <= spiNextState;
	end

	always_comb
	begin
		spiNextState = spiState;
		case (spiState)
			Wait:
				if (!csSync)
					spiNextState = Addr;
			Addr:
				spiNextState = AddrLow;
			AddrLow:
				if (clkSync)
					spiNextState = AddrRise;
			AddrRise:
				spiNextState = AddrHigh;
			AddrHigh:
				if (!clkSync)
					spiNextState = (bitCount == 3'd0) ? Data : AddrLow;
			Data:
				spiNextState = DataLow;
			DataLow:
				if (clkSync)
					spiNextState = DataRise;
			DataRise:
				spiNextState = DataHigh;
			DataHigh:
				if (!clkSync)
					spiNextState = (bitCount == 3'd0) ? Done : DataLow;
			Done:
				spiNextState = Wait;
			default:
				spiNextState = Wait;
		endcase
		if (csSync)
			spiNextState = Wait; // Abort on deselect
	end

	assign bitCountClear = (spiState == Addr) || (spiState == Data);
	assign bitCountInc = (spiState == AddrRise) || (spiState == DataRise);
	assign addrSample = (spiState == AddrRise);
	assign dataSample = (spiState == DataRise);
	assign isWrite = addrShift[DataWidth-1];
	assign dataLoad = (spiState == Data) && !isWrite && spiGrant; // Read data arrives

	always_ff @(posedge theClock)
	begin
		if (SPI_counter_reset || bitCountClear)
			bitCount <= 3'd0;
		else if (bitCountInc)
			bitCount <= bitCount + 3'd1; // Wraps to zero after eight bits
	end

	always_ff @(posedge theClock)
	begin
		if (addrSample)
			addrShift <= {addrShift[DataWidth-2:0], sdiSync};
		if (SPI_counter_reset)
			dataShift <= '0; // Keeps sdo low out of reset
		else if (dataSample)
			dataShift <= {dataShift[DataWidth-2:0], sdiSync};
		else if (dataLoad)
			dataShift <= readData;
	end

	// Read asks right after the address byte, write asks in Done
	assign spiRequest = isWrite ? (spiState == Done) : (spiState == Data);
	assign spiOp = isWrite ? BusWrite : BusRead;
	assign spiAddr = addrShift[AddrWidth-1:0];
	assign spiWriteData = dataShift;

	assign irq = (spiState == Done);
	assign spiSdo = dataShift[DataWidth-1]; // MSB first

endmodule

// File: source/spiRegPkg.sv
// Register map and shared types
package spiRegPkg;

	localparam int DataWidth = 8;
	localparam int AddrWidth = 7;

	// Register addresses
	localparam logic [AddrWidth-1:0] AddrConfig = 7'h00;
	localparam logic [AddrWidth-1:0] AddrLastWrite = 7'h01; // Read-only
	localparam logic [AddrWidth-1:0] AddrCounter = 7'h02; // Read-only
	localparam logic [AddrWidth-1:0] AddrPosX = 7'h03; // Read-only
	localparam logic [AddrWidth-1:0] AddrPosY = 7'h04; // Read-only
	localparam logic [AddrWidth-1:0] AddrMode = 7'h05;
	localparam logic [AddrWidth-1:0] AddrPixelR = 7'h12;
	localparam logic [AddrWidth-1:0] AddrPixelG = 7'h13;
	localparam logic [AddrWidth-1:0] AddrPixelB = 7'h14;
	localparam logic [AddrWidth-1:0] AddrLed = 7'h16;

	localparam logic [DataWidth-1:0] UnmappedValue = 8'h0F;
	localparam int ScanRows = 12; // Y wraps after ScanRows-1

	typedef enum logic {
		BusRead,
		BusWrite
	} busOp_t;

	typedef enum logic [3:0] {
		Wait,
		Addr,
		AddrLow,
		AddrRise,
		AddrHigh,
		Data,
		DataLow,
		DataRise,
		DataHigh,
		Done
	} spiState_t;

	typedef enum logic [1:0] {
		Idle,
		WriteX,
		WriteY,
		WriteCount
	} scanState_t;

endpackage
